/* design/int_pipe_pkg.sv */
// Shared widths and encodings for the RV32I integer ALU pipeline
`default_nettype none

package int_pipe_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Data path width
  localparam int XLEN = 32;

  // Register index width, always 5 bits in the encoding
  localparam int REG_ADDR_W = 5;

  // Instruction word width
  localparam int INSTR_W = 32;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////

  // Only the two ALU classes are decoded
  // Everything else falls to illegal
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_OP_IMM = 7'h13
  } opcode_e;

  //////////////////////////////
  // ALU operations
  //////////////////////////////

  // One code per operation, shared by R-type and I-type forms
  // Compares return 0 or 1 in bit 0
  typedef enum logic [3:0] {
    // Arithmetic
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    // Shifts, amount from operand b bits 4:0
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    // Set less than, signed and unsigned
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    // Bitwise logic
    ALU_XOR  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

endpackage

`default_nettype wire

/* design/register_file.sv */
// General-purpose register file, two read ports and one write port, x0 reads zero
`timescale 1ns/1ps
`default_nettype none

module register_file import int_pipe_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Read ports, combinational
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,
  // Write port
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  // One past the highest implemented index
  localparam logic [REG_ADDR_W:0] REG_LIMIT = (REG_ADDR_W+1)'(NUM_REGS);

  // No storage for x0
  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

  // x0 and unimplemented indexes read zero
  function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
    logic [XLEN-1:0] data;
    data = '0;
    if ((addr != '0) && ({1'b0, addr} < REG_LIMIT)) begin
      data = regs_q[addr];
    end
    return data;
  endfunction

  assign rdata_a_o = read_reg(raddr_a_i);
  assign rdata_b_o = read_reg(raddr_b_i);

  // Single write port, x0 writes dropped
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0) && ({1'b0, waddr_i} < REG_LIMIT)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* design/id_decode.sv */
// Decode stage for RV32I OP and OP-IMM with register read, forwarding and ID/EX register
`timescale 1ns/1ps
`default_nettype none

module id_decode import int_pipe_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Instruction port
  input  logic                  instr_valid_i,
  input  logic [INSTR_W-1:0]    instr_i,
  output logic                  instr_ready_o,
  // Register file read
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  // EX/WB slot forwarding
  input  logic                  ex_fwd_valid_i,
  input  logic [REG_ADDR_W-1:0] ex_fwd_rd_i,
  input  logic [XLEN-1:0]       ex_fwd_data_i,
  // Register write forwarding
  input  logic                  wb_fwd_valid_i,
  input  logic [REG_ADDR_W-1:0] wb_fwd_rd_i,
  input  logic [XLEN-1:0]       wb_fwd_data_i,
  // To execute stage
  output logic                  id_valid_o,
  input  logic                  ex_ready_i,
  output alu_op_e               id_alu_op_o,
  output logic [XLEN-1:0]       id_opa_o,
  output logic [XLEN-1:0]       id_opb_o,
  output logic [REG_ADDR_W-1:0] id_rd_o,
  output logic                  id_illegal_o
);

  localparam logic [REG_ADDR_W:0] REG_LIMIT = (REG_ADDR_W+1)'(NUM_REGS);

  //////////////////////////////
  // Field extraction
  //////////////////////////////

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       imm_i;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];
  // I-immediate, sign-extended
  assign imm_i  = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

  //////////////////////////////
  // Decoder
  //////////////////////////////

  alu_op_e alu_op;
  logic    use_imm;
  logic    bad_enc;
  logic    bad_reg;

  always_comb begin
    alu_op  = ALU_ADD;
    use_imm = 1'b0;
    bad_enc = 1'b0;
    case (opcode)
      OPCODE_OP: begin
        // funct7 selects SUB and SRA
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op = ALU_ADD;
          {7'h20, 3'b000}: alu_op = ALU_SUB;
          {7'h00, 3'b001}: alu_op = ALU_SLL;
          {7'h00, 3'b010}: alu_op = ALU_SLT;
          {7'h00, 3'b011}: alu_op = ALU_SLTU;
          {7'h00, 3'b100}: alu_op = ALU_XOR;
          {7'h00, 3'b101}: alu_op = ALU_SRL;
          {7'h20, 3'b101}: alu_op = ALU_SRA;
          {7'h00, 3'b110}: alu_op = ALU_OR;
          {7'h00, 3'b111}: alu_op = ALU_AND;
          default:         bad_enc = 1'b1;
        endcase
      end
      OPCODE_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000: alu_op = ALU_ADD;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          // Shift-immediates keep funct7 in the upper imm bits
          3'b001: begin
            alu_op  = ALU_SLL;
            bad_enc = (funct7 != 7'h00);
          end
          default: begin
            alu_op  = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            bad_enc = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      default: bad_enc = 1'b1;
    endcase
  end

  // Index range check, rs2 only when read
  assign bad_reg = ({1'b0, rd} >= REG_LIMIT) || ({1'b0, rs1} >= REG_LIMIT) ||
                   (!use_imm && ({1'b0, rs2} >= REG_LIMIT));

  //////////////////////////////
  // Operand read
  //////////////////////////////

  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;

  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;

  // Write landing this edge is not yet visible in the file
  assign src_a = (wb_fwd_valid_i && (wb_fwd_rd_i == rs1) && (rs1 != '0)) ?
                 wb_fwd_data_i : rf_rdata_a_i;
  assign src_b = (wb_fwd_valid_i && (wb_fwd_rd_i == rs2) && (rs2 != '0)) ?
                 wb_fwd_data_i : rf_rdata_b_i;

  //////////////////////////////
  // ID/EX register
  //////////////////////////////

  logic                  id_valid_q;
  logic                  id_free;
  alu_op_e               alu_op_q;
  logic [XLEN-1:0]       opa_q;
  logic [XLEN-1:0]       opb_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [REG_ADDR_W-1:0] rs1_q;
  logic [REG_ADDR_W-1:0] rs2_q;
  logic                  illegal_q;

  // Slot empty or draining this cycle
  assign id_free       = !id_valid_q || ex_ready_i;
  assign instr_ready_o = !rst_i && id_free;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_valid_q <= 1'b0;
    end else if (id_free) begin
      id_valid_q <= instr_valid_i;
    end
  end

  // Payload only on accept
  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      alu_op_q  <= alu_op;
      opa_q     <= src_a;
      opb_q     <= use_imm ? imm_i : src_b;
      rd_q      <= rd;
      rs1_q     <= rs1;
      // x0 never matches, so immediates skip forwarding
      rs2_q     <= use_imm ? '0 : rs2;
      illegal_q <= bad_enc || bad_reg;
    end
  end

  // EX/WB slot is the youngest writer while this slot waits
  assign id_opa_o = (ex_fwd_valid_i && (ex_fwd_rd_i == rs1_q) && (rs1_q != '0)) ?
                    ex_fwd_data_i : opa_q;
  assign id_opb_o = (ex_fwd_valid_i && (ex_fwd_rd_i == rs2_q) && (rs2_q != '0)) ?
                    ex_fwd_data_i : opb_q;

  assign id_valid_o   = id_valid_q;
  assign id_alu_op_o  = alu_op_q;
  assign id_rd_o      = rd_q;
  assign id_illegal_o = illegal_q;

endmodule

`default_nettype wire

/* design/ex_alu.sv */
// Execute stage with the integer ALU and the EX/WB register
`timescale 1ns/1ps
`default_nettype none

module ex_alu import int_pipe_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // From decode
  input  logic                  id_valid_i,
  output logic                  ex_ready_o,
  input  alu_op_e               id_alu_op_i,
  input  logic [XLEN-1:0]       id_opa_i,
  input  logic [XLEN-1:0]       id_opb_i,
  input  logic [REG_ADDR_W-1:0] id_rd_i,
  input  logic                  id_illegal_i,
  // To result stage, also the EX forwarding source
  output logic                  ex_valid_o,
  input  logic                  wb_ready_i,
  output logic [REG_ADDR_W-1:0] ex_rd_o,
  output logic [XLEN-1:0]       ex_data_o,
  output logic                  ex_illegal_o
);

  //////////////////////////////
  // ALU
  //////////////////////////////

  logic [4:0]      shamt;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] res_d;

  // RV32I shift amount
  assign shamt = id_opb_i[4:0];

  always_comb begin
    case (id_alu_op_i)
      ALU_ADD:  alu_res = id_opa_i + id_opb_i;
      ALU_SUB:  alu_res = id_opa_i - id_opb_i;
      ALU_SLL:  alu_res = id_opa_i << shamt;
      ALU_SRL:  alu_res = id_opa_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:  alu_res = $unsigned($signed(id_opa_i) >>> shamt);
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(id_opa_i) < $signed(id_opb_i)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, id_opa_i < id_opb_i};
      ALU_XOR:  alu_res = id_opa_i ^ id_opb_i;
      ALU_OR:   alu_res = id_opa_i | id_opb_i;
      ALU_AND:  alu_res = id_opa_i & id_opb_i;
      default:  alu_res = '0;
    endcase
  end

  // Illegal instructions report zero
  assign res_d = id_illegal_i ? '0 : alu_res;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  logic                  ex_valid_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [XLEN-1:0]       data_q;
  logic                  illegal_q;

  // Accept when empty or when the result leaves
  assign ex_ready_o = !ex_valid_q || wb_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_valid_q <= 1'b0;
    end else if (ex_ready_o) begin
      ex_valid_q <= id_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_valid_i && ex_ready_o) begin
      rd_q      <= id_rd_i;
      data_q    <= res_d;
      illegal_q <= id_illegal_i;
    end
  end

  assign ex_valid_o   = ex_valid_q;
  assign ex_rd_o      = rd_q;
  assign ex_data_o    = data_q;
  assign ex_illegal_o = illegal_q;

endmodule

`default_nettype wire

/* design/wb_result.sv */
// Result stage, presents the EX/WB slot on the result port and writes the register file
`timescale 1ns/1ps
`default_nettype none

module wb_result import int_pipe_pkg::*; (
  // From execute
  input  logic                  ex_valid_i,
  output logic                  wb_ready_o,
  input  logic [REG_ADDR_W-1:0] ex_rd_i,
  input  logic [XLEN-1:0]       ex_data_i,
  input  logic                  ex_illegal_i,
  // Result port
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output logic [REG_ADDR_W-1:0] res_rd_o,
  output logic [XLEN-1:0]       res_data_o,
  output logic                  res_illegal_o,
  // Register file write
  output logic                  rf_we_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o
);

  logic res_accept;

  //////////////////////////////
  // Result handshake
  //////////////////////////////

  // Slot contents go straight out
  assign res_valid_o   = ex_valid_i;
  assign res_rd_o      = ex_rd_i;
  assign res_data_o    = ex_data_i;
  assign res_illegal_o = ex_illegal_i;

  // Empty slot never blocks execute
  assign wb_ready_o = res_ready_i || !ex_valid_i;

  assign res_accept = ex_valid_i && res_ready_i;

  //////////////////////////////
  // Register write
  //////////////////////////////

  // Commit on the accepting edge only
  // Illegal and x0 destinations write nothing
  assign rf_we_o    = res_accept && !ex_illegal_i && (ex_rd_i != '0);
  assign rf_waddr_o = ex_rd_i;
  assign rf_wdata_o = ex_data_i;

endmodule

`default_nettype wire

/* design/int_pipe_core.sv */
// Top level of the RV32I ALU pipeline, connects decode, execute, result and register file
`timescale 1ns/1ps
`default_nettype none

module int_pipe_core import int_pipe_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Instruction port
  input  logic                  instr_valid_i,
  input  logic [INSTR_W-1:0]    instr_i,
  output logic                  instr_ready_o,
  // Result port
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output logic [REG_ADDR_W-1:0] res_rd_o,
  output logic [XLEN-1:0]       res_data_o,
  output logic                  res_illegal_o
);

  // Decode to execute
  logic                  id_valid;
  logic                  ex_ready;
  alu_op_e               id_alu_op;
  logic [XLEN-1:0]       id_opa;
  logic [XLEN-1:0]       id_opb;
  logic [REG_ADDR_W-1:0] id_rd;
  logic                  id_illegal;

  // Execute to result
  logic                  ex_valid;
  logic                  wb_ready;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [XLEN-1:0]       ex_data;
  logic                  ex_illegal;
  logic                  ex_fwd_valid;

  // Register file
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;
  logic [REG_ADDR_W-1:0] rf_raddr_a;
  logic [REG_ADDR_W-1:0] rf_raddr_b;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;

  // Illegal slot holds no writer
  assign ex_fwd_valid = ex_valid && !ex_illegal;

  //////////////////////////////
  // Decode stage
  //////////////////////////////

  id_decode #(
    .NUM_REGS       ( NUM_REGS      )
  ) id_decode_i (
    .clk_i          ( clk_i         ),
    .rst_i          ( rst_i         ),
    .instr_valid_i  ( instr_valid_i ),
    .instr_i        ( instr_i       ),
    .instr_ready_o  ( instr_ready_o ),
    .rf_raddr_a_o   ( rf_raddr_a    ),
    .rf_raddr_b_o   ( rf_raddr_b    ),
    .rf_rdata_a_i   ( rf_rdata_a    ),
    .rf_rdata_b_i   ( rf_rdata_b    ),
    .ex_fwd_valid_i ( ex_fwd_valid  ),
    .ex_fwd_rd_i    ( ex_rd         ),
    .ex_fwd_data_i  ( ex_data       ),
    .wb_fwd_valid_i ( rf_we         ), // write port doubles as WB bypass
    .wb_fwd_rd_i    ( rf_waddr      ),
    .wb_fwd_data_i  ( rf_wdata      ),
    .id_valid_o     ( id_valid      ),
    .ex_ready_i     ( ex_ready      ),
    .id_alu_op_o    ( id_alu_op     ),
    .id_opa_o       ( id_opa        ),
    .id_opb_o       ( id_opb        ),
    .id_rd_o        ( id_rd         ),
    .id_illegal_o   ( id_illegal    )
  );

  //////////////////////////////
  // Execute stage
  //////////////////////////////

  ex_alu ex_alu_i (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .id_valid_i   ( id_valid   ),
    .ex_ready_o   ( ex_ready   ),
    .id_alu_op_i  ( id_alu_op  ),
    .id_opa_i     ( id_opa     ),
    .id_opb_i     ( id_opb     ),
    .id_rd_i      ( id_rd      ),
    .id_illegal_i ( id_illegal ),
    .ex_valid_o   ( ex_valid   ),
    .wb_ready_i   ( wb_ready   ),
    .ex_rd_o      ( ex_rd      ),
    .ex_data_o    ( ex_data    ),
    .ex_illegal_o ( ex_illegal )
  );

  //////////////////////////////
  // Result stage
  //////////////////////////////

  wb_result wb_result_i (
    .ex_valid_i    ( ex_valid      ),
    .wb_ready_o    ( wb_ready      ),
    .ex_rd_i       ( ex_rd         ),
    .ex_data_i     ( ex_data       ),
    .ex_illegal_i  ( ex_illegal    ),
    .res_valid_o   ( res_valid_o   ),
    .res_ready_i   ( res_ready_i   ),
    .res_rd_o      ( res_rd_o      ),
    .res_data_o    ( res_data_o    ),
    .res_illegal_o ( res_illegal_o ),
    .rf_we_o       ( rf_we         ),
    .rf_waddr_o    ( rf_waddr      ),
    .rf_wdata_o    ( rf_wdata      )
  );

  //////////////////////////////
  // Register file
  //////////////////////////////

  register_file #(
    .NUM_REGS  ( NUM_REGS   )
  ) register_file_i (
    .clk_i     ( clk_i      ),
    .rst_i     ( rst_i      ),
    .raddr_a_i ( rf_raddr_a ),
    .raddr_b_i ( rf_raddr_b ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b ),
    .we_i      ( rf_we      ),
    .waddr_i   ( rf_waddr   ),
    .wdata_i   ( rf_wdata   )
  );

endmodule

`default_nettype wire

/* tb/int_pipe_vectors.svh */
// Instruction vectors for the ALU pipeline with expected rd, data and illegal flag
`ifndef INT_PIPE_VECTORS_SVH
`define INT_PIPE_VECTORS_SVH

// Columns: instruction word, expected rd, expected data, expected illegal flag
typedef struct packed {
  logic [INSTR_W-1:0]    instr;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       data;
  logic                  illegal;
} vec_row_t;

localparam int NUM_VEC = 33;

localparam vec_row_t VEC_TABLE [NUM_VEC] = '{
  // Immediates from x0, positive and negative
  {32'h00500093, 5'd1,  32'h00000005, 1'b0},  // addi x1, x0, 5
  {32'hFFD00113, 5'd2,  32'hFFFFFFFD, 1'b0},  // addi x2, x0, -3
  {32'h7FF00193, 5'd3,  32'h000007FF, 1'b0},  // addi x3, x0, 2047
  {32'h80000213, 5'd4,  32'hFFFFF800, 1'b0},  // addi x4, x0, -2048
  // All ten register-register operations
  {32'h002082B3, 5'd5,  32'h00000002, 1'b0},  // add  x5, x1, x2
  {32'h40208333, 5'd6,  32'h00000008, 1'b0},  // sub  x6, x1, x2
  {32'h003093B3, 5'd7,  32'h80000000, 1'b0},  // sll  x7, x1, x3
  {32'h00112433, 5'd8,  32'h00000001, 1'b0},  // slt  x8, x2, x1
  {32'h001134B3, 5'd9,  32'h00000000, 1'b0},  // sltu x9, x2, x1
  {32'h0020C533, 5'd10, 32'hFFFFFFF8, 1'b0},  // xor  x10, x1, x2
  {32'h001155B3, 5'd11, 32'h07FFFFFF, 1'b0},  // srl  x11, x2, x1
  {32'h40115633, 5'd12, 32'hFFFFFFFF, 1'b0},  // sra  x12, x2, x1
  {32'h0020E6B3, 5'd13, 32'hFFFFFFFD, 1'b0},  // or   x13, x1, x2
  {32'h0020F733, 5'd14, 32'h00000005, 1'b0},  // and  x14, x1, x2
  // Dependent chain, newest value must win
  {32'h00A08793, 5'd15, 32'h0000000F, 1'b0},  // addi x15, x1, 10
  {32'h00F78833, 5'd16, 32'h0000001E, 1'b0},  // add  x16, x15, x15
  {32'h40F808B3, 5'd17, 32'h0000000F, 1'b0},  // sub  x17, x16, x15
  {32'hFFF7C793, 5'd15, 32'hFFFFFFF0, 1'b0},  // xori x15, x15, -1
  {32'h01078933, 5'd18, 32'h0000000E, 1'b0},  // add  x18, x15, x16
  {32'hFF17A993, 5'd19, 32'h00000001, 1'b0},  // slti x19, x15, -15
  {32'h0017BA13, 5'd20, 32'h00000000, 1'b0},  // sltiu x20, x15, 1
  {32'h0F00EA93, 5'd21, 32'h000000F5, 1'b0},  // ori  x21, x1, 0xf0
  {32'h00FAFB13, 5'd22, 32'h00000005, 1'b0},  // andi x22, x21, 0xf
  {32'h00409B93, 5'd23, 32'h00000050, 1'b0},  // slli x23, x1, 4
  {32'h01C15C13, 5'd24, 32'h0000000F, 1'b0},  // srli x24, x2, 28
  {32'h40425C93, 5'd25, 32'hFFFFFF80, 1'b0},  // srai x25, x4, 4
  // x0 reports its data but keeps reading zero
  {32'h00708013, 5'd0,  32'h0000000C, 1'b0},  // addi x0, x1, 7
  {32'h00100D33, 5'd26, 32'h00000005, 1'b0},  // add  x26, x0, x1
  // Illegal encodings, data zero and no write
  // The mul sits right ahead of a reader of x2
  {32'h02109193, 5'd3,  32'h00000000, 1'b1},  // slli x3 with bad funct7
  {32'h123450B7, 5'd1,  32'h00000000, 1'b1},  // lui x1, not decoded
  {32'h02108133, 5'd2,  32'h00000000, 1'b1},  // mul x2, not decoded
  {32'h00208DB3, 5'd27, 32'h00000002, 1'b0},  // add  x27, x1, x2
  {32'h0001EE33, 5'd28, 32'h000007FF, 1'b0}   // or   x28, x3, x0
};

`endif

/* tb/int_pipe_core_tb.sv */
// Testbench for the RV32I ALU pipeline, table-driven with random result back-pressure
`timescale 1ns/1ps
`default_nettype none

module int_pipe_core_tb import int_pipe_pkg::*; ;

  localparam int NUM_REGS     = 32;
  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_WAIT     = 200;

  `include "int_pipe_vectors.svh"

  logic                  clk_i;
  logic                  rst_i;
  logic                  instr_valid_i;
  logic [INSTR_W-1:0]    instr_i;
  logic                  instr_ready_o;
  logic                  res_valid_o;
  logic                  res_ready_i;
  logic [REG_ADDR_W-1:0] res_rd_o;
  logic [XLEN-1:0]       res_data_o;
  logic                  res_illegal_o;

  // Scoreboard state
  int          exp_idx_q[$];
  int          acc_cycle_q[$];
  int          cycle_cnt;
  int          error_count;
  int          timeout_count;
  int          result_count;
  bit          check_latency;
  bit          random_ready;
  int unsigned seed_val;

  int_pipe_core #(
    .NUM_REGS      ( NUM_REGS      )
  ) DUT (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .instr_ready_o ( instr_ready_o ),
    .res_valid_o   ( res_valid_o   ),
    .res_ready_i   ( res_ready_i   ),
    .res_rd_o      ( res_rd_o      ),
    .res_data_o    ( res_data_o    ),
    .res_illegal_o ( res_illegal_o )
  );

  //////////////////////////////
  // Clock and cycle count
  //////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Result back-pressure, random once enabled
  always @(posedge clk_i) begin
    if (random_ready) begin
      res_ready_i <= (($urandom % 3) != 0);
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0t: %s = 0x%08h, expected 0x%08h", $time, name, actual, expected);
    end
  endtask

  // Present one row and wait for its handshake
  task automatic send_instr(input int idx, input bit with_gaps);
    int          wait_cnt;
    int unsigned gap;
    wait_cnt = 0;
    gap      = with_gaps ? ($urandom % 3) : 0;
    // Idle cycles ahead of the next instruction
    if (gap != 0) begin
      @(posedge clk_i);
      instr_valid_i <= 1'b0;
      repeat (gap - 1) @(posedge clk_i);
    end
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    instr_i       <= VEC_TABLE[idx].instr;
    @(negedge clk_i);
    while (!instr_ready_o && (wait_cnt < MAX_WAIT)) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (instr_ready_o) begin
      // Transfer happens on the coming edge
      exp_idx_q.push_back(idx);
      acc_cycle_q.push_back(cycle_cnt);
    end else begin
      timeout_count++;
      $display("Timeout: instr_ready_o stayed low while sending row %0d", idx);
    end
  endtask

  // Stop sending and wait until every result is back
  task automatic drain_results();
    int wait_cnt;
    wait_cnt = 0;
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    @(negedge clk_i);
    while ((exp_idx_q.size() != 0) && (wait_cnt < MAX_WAIT)) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (exp_idx_q.size() != 0) begin
      timeout_count++;
      $display("Timeout: %0d results never came back", exp_idx_q.size());
    end
  endtask

  //////////////////////////////
  // Result monitor
  //////////////////////////////

  // Sampled mid-cycle, a hit here transfers on the next rising edge
  always @(negedge clk_i) begin : result_monitor
    int       idx;
    int       acc;
    vec_row_t row;
    if (!rst_i && res_valid_o && res_ready_i) begin
      if (exp_idx_q.size() == 0) begin
        error_count++;
        $display("Result for rd %0d arrived with no instruction outstanding", res_rd_o);
      end else begin
        idx = exp_idx_q.pop_front();
        acc = acc_cycle_q.pop_front();
        row = VEC_TABLE[idx];
        check_value("res_rd_o", 32'(res_rd_o), 32'(row.rd));
        check_value("res_data_o", res_data_o, row.data);
        check_value("res_illegal_o", 32'(res_illegal_o), 32'(row.illegal));
        if (check_latency) begin
          check_value("result latency", 32'(cycle_cnt - acc), 32'd2);
        end
        result_count++;
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed_val      = $urandom(8);
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    res_ready_i   = 1'b0;
    cycle_cnt     = 0;
    error_count   = 0;
    timeout_count = 0;
    result_count  = 0;
    check_latency = 1'b1;
    random_ready  = 1'b0;

    // Nothing ready or valid while in reset
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("instr_ready_o", 32'(instr_ready_o), 32'd0);
    check_value("res_valid_o", 32'(res_valid_o), 32'd0);
    repeat (RESET_CYCLES - 1) @(posedge clk_i);
    rst_i       <= 1'b0;
    res_ready_i <= 1'b1;
    @(negedge clk_i);
    check_value("instr_ready_o", 32'(instr_ready_o), 32'd1);
    check_value("res_valid_o", 32'(res_valid_o), 32'd0);

    // Whole table back-to-back with the result port always ready
    for (int i = 0; (i < NUM_VEC) && (timeout_count == 0); i++) begin
      send_instr(i, 1'b0);
    end
    drain_results();

    // Same table again under random stalls and gaps
    // Every register is rewritten before it is read, so the expected values repeat
    check_latency = 1'b0;
    random_ready  = 1'b1;
    for (int i = 0; (i < NUM_VEC) && (timeout_count == 0); i++) begin
      send_instr(i, 1'b1);
    end
    drain_results();

    // Each result exactly once
    check_value("result count", 32'(result_count), 32'(2 * NUM_VEC));

    $display("Summary: %0d results, %0d errors, %0d timeouts",
             result_count, error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0)) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* int_pipe_core.f */
design/int_pipe_pkg.sv
design/register_file.sv
design/id_decode.sv
design/ex_alu.sv
design/wb_result.sv
design/int_pipe_core.sv
+incdir+tb
tb/int_pipe_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f int_pipe_core.f --top-module int_pipe_core_tb \
  && ./obj_dir/Vint_pipe_core_tb > sim.log 2>&1 \
  || echo "Build or run did not complete"

cat sim.log 2>/dev/null

grep -q "^Simulation PASSED$" sim.log 2>/dev/null \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
